// ==== logic/dma_pkg.sv ====
package dma_pkg;

   localparam int DATA_W      = 32;
   localparam int BYTES_W     = 2;    // byte offset within a word

   localparam int MEM_DEPTH   = 256;
   localparam int MEM_AW      = 8;

   localparam int N_CHAN      = 2;
   localparam int N_REQ       = N_CHAN + 1;  // channels plus apb

   localparam int CNT_W       = 8;

   localparam int APB_AW      = 12;
   localparam int MEM_WIN_BIT = 11;   // set: word window at paddr[9:2]

   // per channel register block
   localparam logic [APB_AW-1:0] REG_SRC     = 'h0;
   localparam logic [APB_AW-1:0] REG_CNT     = 'h4;
   localparam logic [APB_AW-1:0] REG_CTRL    = 'h8;
   localparam logic [APB_AW-1:0] CHAN_STRIDE = 'h10;

endpackage

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;
   import dma_pkg::*;

   logic              req;
   logic              we;
   logic [MEM_AW-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic              gnt;
   logic              rvalid;  // one cycle after an accepted read
   logic [DATA_W-1:0] rdata;

   modport requester (
      output req, we, addr, wdata,
      input  gnt, rvalid, rdata
   );

   modport server (
      input  req, we, addr, wdata,
      output gnt, rvalid, rdata
   );

endinterface

// ==== logic/burst_align.sv ====
`timescale 1ns/1ps

module burst_align (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         start_i,
   input  logic [dma_pkg::BYTES_W-1:0]  offset_i,
   input  logic                         in_valid_i,
   input  logic                         in_last_i,
   input  logic [dma_pkg::DATA_W-1:0]   in_data_i,
   output logic                         out_valid_o,
   output logic                         out_last_o,
   output logic [dma_pkg::DATA_W-1:0]   out_data_o
);
   import dma_pkg::*;

   logic [DATA_W-1:0]   stored_q;
   logic                have_q;   // stored_q holds a word of this burst
   logic                armed_q;
   logic [2*DATA_W-1:0] pair;

   // upper bytes of stored word, topped up from the incoming one
   assign pair        = {in_data_i, stored_q};
   assign out_data_o  = pair[{offset_i, 3'b000} +: DATA_W];
   assign out_valid_o = have_q & in_valid_i;
   assign out_last_o  = out_valid_o & in_last_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         have_q  <= 1'b0;
         armed_q <= 1'b0;
      end else begin
         if (start_i) begin
            have_q  <= 1'b0;
            armed_q <= 1'b1;
         end else if (in_valid_i) begin
            have_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_valid_i) begin
         stored_q <= in_data_i;
      end
   end

   // data before the first start would be joined with garbage
   a_no_data_before_start: assert property (
      @(posedge clk_i) disable iff (rst_i) !armed_q |-> !in_valid_i
   );

endmodule

// ==== logic/read_channel.sv ====
`timescale 1ns/1ps

module read_channel (
   input  logic                                         clk_i,
   input  logic                                         rst_i,
   input  logic                                         start_i,
   input  logic [dma_pkg::MEM_AW+dma_pkg::BYTES_W-1:0]  src_i,   // byte address
   input  logic [dma_pkg::CNT_W-1:0]                    cnt_i,
   output logic                                         busy_o,
   mem_bus_if.requester                                 mem,
   output logic                                         out_valid_o,
   output logic                                         out_last_o,
   output logic [dma_pkg::DATA_W-1:0]                   out_data_o
);
   import dma_pkg::*;

   typedef logic [CNT_W:0] count_t;  // one extra read beyond cnt

   logic [MEM_AW-1:0]  addr_q;
   logic [BYTES_W-1:0] offset_q;
   count_t             issue_q;    // reads left to issue
   count_t             ret_q;      // words left to come back
   logic               busy_q;
   logic               go;
   logic               final_ret;

   assign go        = start_i & ~busy_q;  // start while busy is dropped
   assign busy_o    = busy_q;
   assign final_ret = ret_q == count_t'(1);

   assign mem.req   = busy_q && (issue_q != '0);
   assign mem.we    = 1'b0;
   assign mem.addr  = addr_q;
   assign mem.wdata = '0;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q   <= 1'b0;
         addr_q   <= '0;
         offset_q <= '0;
         issue_q  <= '0;
         ret_q    <= '0;
      end else if (go) begin
         busy_q   <= 1'b1;
         addr_q   <= src_i[MEM_AW+BYTES_W-1:BYTES_W];
         offset_q <= src_i[BYTES_W-1:0];
         issue_q  <= {1'b0, cnt_i} + 1'b1;
         ret_q    <= {1'b0, cnt_i} + 1'b1;
      end else begin
         if (mem.req && mem.gnt) begin
            addr_q  <= addr_q + 1'b1;  // wraps at memory end
            issue_q <= issue_q - 1'b1;
         end
         if (mem.rvalid) begin
            ret_q <= ret_q - 1'b1;
            if (final_ret) begin
               busy_q <= 1'b0;  // last aligned word leaves this cycle
            end
         end
      end
   end

   burst_align u_align (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (go),
      .offset_i    (offset_q),
      .in_valid_i  (mem.rvalid),
      .in_last_i   (final_ret),
      .in_data_i   (mem.rdata),
      .out_valid_o (out_valid_o),
      .out_last_o  (out_last_o),
      .out_data_o  (out_data_o)
   );

   // a stray response means the arbiter routed someone else's read here
   a_rvalid_outstanding: assert property (
      @(posedge clk_i) disable iff (rst_i) mem.rvalid |-> (ret_q != issue_q)
   );

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
   input  logic                        clk_i,
   input  logic                        rst_i,
   mem_bus_if.server                   req [dma_pkg::N_REQ],
   output logic                        mem_en_o,
   output logic                        mem_we_o,
   output logic [dma_pkg::MEM_AW-1:0]  mem_addr_o,
   output logic [dma_pkg::DATA_W-1:0]  mem_wdata_o,
   input  logic [dma_pkg::DATA_W-1:0]  mem_rdata_i
);
   import dma_pkg::*;

   typedef logic [$clog2(N_REQ)-1:0] idx_t;

   logic [N_REQ-1:0]  req_v;
   logic [N_REQ-1:0]  we_v;
   logic [MEM_AW-1:0] addr_v  [N_REQ];
   logic [DATA_W-1:0] wdata_v [N_REQ];
   logic [N_REQ-1:0]  gnt_v;
   idx_t              win;
   idx_t              ptr_q;      // last winner
   idx_t              rd_idx_q;
   logic              rd_pend_q;

   for (genvar g = 0; g < N_REQ; g++) begin : g_port
      assign req_v[g]      = req[g].req;
      assign we_v[g]       = req[g].we;
      assign addr_v[g]     = req[g].addr;
      assign wdata_v[g]    = req[g].wdata;
      assign req[g].gnt    = gnt_v[g];
      assign req[g].rvalid = rd_pend_q && (rd_idx_q == g);
      assign req[g].rdata  = mem_rdata_i;  // only the rvalid owner looks
   end

   // search starts just after the last winner
   always_comb begin
      int idx;
      gnt_v = '0;
      win   = ptr_q;
      for (int i = 1; i <= N_REQ; i++) begin
         idx = (int'(ptr_q) + i) % N_REQ;
         if (gnt_v == '0 && req_v[idx]) begin
            gnt_v[idx] = 1'b1;
            win        = idx_t'(idx);
         end
      end
   end

   assign mem_en_o    = |gnt_v;
   assign mem_we_o    = we_v[win];
   assign mem_addr_o  = addr_v[win];
   assign mem_wdata_o = wdata_v[win];

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ptr_q     <= idx_t'(N_REQ - 1);  // apb first after reset
         rd_idx_q  <= '0;
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= mem_en_o & ~mem_we_o;
         if (mem_en_o) begin
            ptr_q    <= win;
            rd_idx_q <= win;
         end
      end
   end

   a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_v));

endmodule

// ==== logic/word_memory.sv ====
`timescale 1ns/1ps

module word_memory (
   input  logic                        clk_i,
   input  logic                        en_i,
   input  logic                        we_i,
   input  logic [dma_pkg::MEM_AW-1:0]  addr_i,
   input  logic [dma_pkg::DATA_W-1:0]  wdata_i,
   output logic [dma_pkg::DATA_W-1:0]  rdata_o
);
   import dma_pkg::*;

   logic [DATA_W-1:0] ram [MEM_DEPTH];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            ram[addr_i] <= wdata_i;
         end else begin
            rdata_o <= ram[addr_i];  // valid the cycle after the read
         end
      end
   end

endmodule

// ==== logic/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs (
   input  logic                                         clk_i,
   input  logic                                         rst_i,
   input  logic                                         psel_i,
   input  logic                                         penable_i,
   input  logic                                         pwrite_i,
   input  logic [dma_pkg::APB_AW-1:0]                   paddr_i,
   input  logic [dma_pkg::DATA_W-1:0]                   pwdata_i,
   output logic [dma_pkg::DATA_W-1:0]                   prdata_o,
   output logic                                         pready_o,
   mem_bus_if.requester                                 mem,
   output logic [dma_pkg::MEM_AW+dma_pkg::BYTES_W-1:0]  src_o [dma_pkg::N_CHAN],
   output logic [dma_pkg::CNT_W-1:0]                    cnt_o [dma_pkg::N_CHAN],
   output logic [dma_pkg::N_CHAN-1:0]                   start_o,
   input  logic [dma_pkg::N_CHAN-1:0]                   busy_i
);
   import dma_pkg::*;

   logic              access;
   logic              win;
   logic              reg_wr;
   logic              rd_issued_q;  // window read waiting on rvalid
   logic [APB_AW-1:0] chan_sel;
   logic [APB_AW-1:0] reg_off;

   assign access   = psel_i & penable_i;
   assign win      = paddr_i[MEM_WIN_BIT];
   assign reg_wr   = access & ~win & pwrite_i;
   assign chan_sel = paddr_i / CHAN_STRIDE;
   assign reg_off  = paddr_i % CHAN_STRIDE;

   assign mem.req   = access & win & ~rd_issued_q;
   assign mem.we    = pwrite_i;
   assign mem.addr  = paddr_i[MEM_AW+1:2];
   assign mem.wdata = pwdata_i;

   always_comb begin
      pready_o = 1'b0;
      if (access) begin
         if (!win) begin
            pready_o = 1'b1;  // no wait states on registers
         end else if (pwrite_i) begin
            pready_o = mem.gnt;
         end else begin
            pready_o = mem.rvalid;
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (win) begin
         prdata_o = mem.rdata;
      end else begin
         for (int c = 0; c < N_CHAN; c++) begin
            if (chan_sel == c) begin
               case (reg_off)
                  REG_SRC:  prdata_o = DATA_W'(src_o[c]);
                  REG_CNT:  prdata_o = DATA_W'(cnt_o[c]);
                  REG_CTRL: prdata_o = DATA_W'(busy_i[c]);
                  default:  prdata_o = '0;
               endcase
            end
         end
      end
   end

   // any write to ctrl kicks the channel
   always_comb begin
      for (int c = 0; c < N_CHAN; c++) begin
         start_o[c] = reg_wr && (chan_sel == c) && (reg_off == REG_CTRL);
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         rd_issued_q <= 1'b0;
         for (int c = 0; c < N_CHAN; c++) begin
            src_o[c] <= '0;
            cnt_o[c] <= '0;
         end
      end else begin
         if (mem.req && mem.gnt && !pwrite_i) begin
            rd_issued_q <= 1'b1;
         end else if (mem.rvalid) begin
            rd_issued_q <= 1'b0;
         end
         for (int c = 0; c < N_CHAN; c++) begin
            if (reg_wr && chan_sel == c) begin
               if (reg_off == REG_SRC) begin
                  src_o[c] <= pwdata_i[MEM_AW+BYTES_W-1:0];
               end
               if (reg_off == REG_CNT) begin
                  cnt_o[c] <= pwdata_i[CNT_W-1:0];
               end
            end
         end
      end
   end

endmodule

// ==== logic/align_dma_top.sv ====
`timescale 1ns/1ps

module align_dma_top (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        psel_i,
   input  logic                        penable_i,
   input  logic                        pwrite_i,
   input  logic [dma_pkg::APB_AW-1:0]  paddr_i,
   input  logic [dma_pkg::DATA_W-1:0]  pwdata_i,
   output logic [dma_pkg::DATA_W-1:0]  prdata_o,
   output logic                        pready_o,
   output logic                        pslverr_o,
   output logic [dma_pkg::N_CHAN-1:0]  out_valid_o,
   output logic [dma_pkg::N_CHAN-1:0]  out_last_o,
   output logic [dma_pkg::DATA_W-1:0]  out_data_o [dma_pkg::N_CHAN]
);
   import dma_pkg::*;

   logic [MEM_AW+BYTES_W-1:0] src [N_CHAN];
   logic [CNT_W-1:0]          cnt [N_CHAN];
   logic [N_CHAN-1:0]         start;
   logic [N_CHAN-1:0]         busy;
   logic                      mem_en;
   logic                      mem_we;
   logic [MEM_AW-1:0]         mem_addr;
   logic [DATA_W-1:0]         mem_wdata;
   logic [DATA_W-1:0]         mem_rdata;

   mem_bus_if bus [N_REQ] ();  // 0 is apb, then the channels

   assign pslverr_o = 1'b0;

   apb_regs u_apb (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .mem       (bus[0]),
      .src_o     (src),
      .cnt_o     (cnt),
      .start_o   (start),
      .busy_i    (busy)
   );

   for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
      read_channel u_chan (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .start_i     (start[c]),
         .src_i       (src[c]),
         .cnt_i       (cnt[c]),
         .busy_o      (busy[c]),
         .mem         (bus[c+1]),
         .out_valid_o (out_valid_o[c]),
         .out_last_o  (out_last_o[c]),
         .out_data_o  (out_data_o[c])
      );
   end

   mem_arbiter u_arb (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req         (bus),
      .mem_en_o    (mem_en),
      .mem_we_o    (mem_we),
      .mem_addr_o  (mem_addr),
      .mem_wdata_o (mem_wdata),
      .mem_rdata_i (mem_rdata)
   );

   word_memory u_mem (
      .clk_i   (clk_i),
      .en_i    (mem_en),
      .we_i    (mem_we),
      .addr_i  (mem_addr),
      .wdata_i (mem_wdata),
      .rdata_o (mem_rdata)
   );

endmodule

// ==== bench/align_dma_tb.sv ====
`timescale 1ns/1ps

module align_dma_tb;
   import dma_pkg::*;

   localparam int          APB_TIMEOUT    = 50;
   localparam int          STREAM_TIMEOUT = 200;
   localparam int          BATCH_LIMIT    = 400;  // window reads while a batch drains
   localparam logic [31:0] SEED           = 32'hb635be68;

   logic                clk;
   logic                rst;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [APB_AW-1:0]   paddr;
   logic [DATA_W-1:0]   pwdata;
   logic [DATA_W-1:0]   prdata;
   logic                pready;
   logic                pslverr;
   logic [N_CHAN-1:0]   out_valid;
   logic [N_CHAN-1:0]   out_last;
   logic [DATA_W-1:0]   out_data [N_CHAN];

   logic                pready_q;  // sampled at the rising edge
   logic [DATA_W-1:0]   prdata_q;
   logic [DATA_W-1:0]   model [MEM_DEPTH];
   logic [31:0]         lfsr;
   logic [N_CHAN-1:0]   mon_busy;
   int                  errors;
   int                  checks;

   align_dma_top dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .pslverr_o   (pslverr),
      .out_valid_o (out_valid),
      .out_last_o  (out_last),
      .out_data_o  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      pready_q <= pready;
      prdata_q <= prdata;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [APB_AW-1:0] window_addr(input int w);
      return APB_AW'((1 << MEM_WIN_BIT) | (w << 2));
   endfunction

   // little endian bytes addr..addr+3, wrapping at the end of memory
   function automatic logic [31:0] expect_word(input int addr);
      logic [31:0] w;
      int          b;
      for (int j = 0; j < 4; j++) begin
         b            = (addr + j) % (MEM_DEPTH * 4);
         w[8*j +: 8]  = model[b / 4][8 * (b % 4) +: 8];
      end
      return w;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   // entered and left on a falling edge
   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      waited  = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!pready_q && waited < APB_TIMEOUT);
      assert (pready_q) else begin
         errors++;
         $display("APB access to address %h never saw pready", addr);
      end
      rdata   = prdata_q;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] wdata);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, wdata, unused);
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] rdata);
      apb_xfer(1'b0, addr, '0, rdata);
   endtask

   task automatic watch_stream(input int ch, input int src, input int cnt);
      int   waited;
      logic seen;
      for (int k = 0; k < cnt; k++) begin
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!out_valid[ch] && waited < STREAM_TIMEOUT);
         seen = out_valid[ch];
         assert (seen) else begin
            errors++;
            $display("channel %0d stream stalled before word %0d of %0d", ch, k, cnt);
         end
         if (!seen) break;
         check_value($sformatf("out_data_o[%0d]", ch), out_data[ch], expect_word(src + 4 * k));
         check_value($sformatf("out_last_o[%0d]", ch), out_last[ch], k == cnt - 1);
      end
      repeat (3) begin  // nothing past the last word
         @(negedge clk);
         check_value($sformatf("out_valid_o[%0d]", ch), out_valid[ch], 0);
      end
      mon_busy[ch] = 1'b0;
   endtask

   task automatic start_case(input int ch, input int src, input int cnt);
      int base;
      base = ch * CHAN_STRIDE;
      apb_write(APB_AW'(base) + REG_SRC, src);
      apb_write(APB_AW'(base) + REG_CNT, cnt);
      mon_busy[ch] = 1'b1;
      fork
         watch_stream(ch, src, cnt);
      join_none
      apb_write(APB_AW'(base) + REG_CTRL, 32'h1);
   endtask

   // memory reads compete with the running channels
   task automatic finish_batch();
      int          n;
      int          a;
      logic [31:0] data;
      n = 0;
      while (mon_busy != '0 && n < BATCH_LIMIT) begin
         a = int'(take_bits(8));
         apb_read(window_addr(a), data);
         check_value("prdata_o", data, model[a]);
         n++;
      end
      assert (mon_busy == '0) else begin
         errors++;
         $display("transfers still running after %0d window reads", n);
      end
      for (int c = 0; c < N_CHAN; c++) begin
         apb_read(APB_AW'(c * CHAN_STRIDE) + REG_CTRL, data);
         check_value($sformatf("busy[%0d]", c), data[0], 0);
      end
   endtask

   initial begin
      int          fd;
      int          ch;
      int          cnt;
      int          together;
      logic [31:0] src;
      logic [31:0] data;
      string       line;
      errors   = 0;
      checks   = 0;
      lfsr     = SEED;
      mon_busy = '0;
      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      repeat (4) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_value("out_valid_o", out_valid, 0);
      check_value("out_last_o", out_last, 0);
      check_value("pready_o", pready, 0);
      check_value("pslverr_o", pslverr, 0);
      for (int c = 0; c < N_CHAN; c++) begin
         apb_read(APB_AW'(c * CHAN_STRIDE) + REG_CTRL, data);
         check_value($sformatf("busy[%0d]", c), data[0], 0);
      end

      for (int i = 0; i < MEM_DEPTH; i++) begin
         model[i] = take_bits(32);
         apb_write(window_addr(i), model[i]);
      end
      for (int i = 0; i < MEM_DEPTH; i++) begin
         apb_read(window_addr(i), data);
         check_value("prdata_o", data, model[i]);
      end

      fd = $fopen("bench/align_dma_cases.txt", "r");
      assert (fd != 0) else begin
         errors++;
         $display("cannot open the cases file");
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
               assert ($sscanf(line, "%d %h %d %d", ch, src, cnt, together) == 4) else begin
                  errors++;
                  $display("unreadable line in cases file: %s", line);
               end
               start_case(ch, src, cnt);
               if (together == 0) finish_batch();
            end
         end
         $fclose(fd);
         finish_batch();  // file may end inside a batch
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== bench/align_dma_cases.txt ====
# channel  src_byte_addr(hex)  word_count  start_with_next(1=yes)
# source addresses wrap at 1024 bytes
0 000 8 0
1 010 4 0
0 001 5 0
1 002 1 0
0 003 6 0
1 3fd 3 0
0 021 12 1
1 102 9 0
0 0c3 1 0
0 0c3 1 0
1 040 16 1
0 207 16 0

// ==== compile.f ====
logic/dma_pkg.sv
logic/mem_bus_if.sv
logic/burst_align.sv
logic/read_channel.sv
logic/mem_arbiter.sv
logic/word_memory.sv
logic/apb_regs.sv
logic/align_dma_top.sv
bench/align_dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= align_dma_tb
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
